// File: tb.f
+incdir+.
mac_types_pkg.sv
dot_stream_pkg.sv
mac16_accum.sv
dot_ingress.sv
dot_sequencer.sv
dot_engine_top.sv
dot_engine_properties.sv
tb_dot_engine.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the simulator's.
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_dot_engine \
    -o tb_dot_engine_sim \
    && ./obj_dir/tb_dot_engine_sim \
    || exit 1

// File: tb_dot_engine.sv
`timescale 1ns/1ns
`include "dot_config.svh"

module tb_dot_engine
    import dot_stream_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 5000;

    logic        clk;
    logic        i_rst;
    logic        i_in_valid;
    dot_word_t   i_in_word;
    logic        o_in_credit;
    logic        o_res_valid;
    dot_result_t o_res;
    logic        i_res_credit;
    logic        o_fmt_err;

    integer      seed;
    int          in_credits;                   // Credits the sender holds.
    int          in_returned;                  // Credits seen since reset.
    int          res_owed;                     // Results whose credit is still to go back.
    int          res_count;
    logic        hold_credits;
    dot_word_t   tx_q[$];
    dot_result_t exp_q[$];
    dot_result_t expd;
    dot_word_t   next_word;
    dot_word_t   stray;
    int          res_mark;
    int          ret_mark;
    int          n;

    dot_engine_top i_dot_engine_top (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_in_valid   (i_in_valid),
        .i_in_word    (i_in_word),
        .o_in_credit  (o_in_credit),
        .o_res_valid  (o_res_valid),
        .o_res        (o_res),
        .i_res_credit (i_res_credit),
        .o_fmt_err    (o_fmt_err)
    );

    bind dot_engine_top dot_engine_properties i_dot_engine_properties (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_in_valid   (i_in_valid),
        .o_in_credit  (o_in_credit),
        .o_res_valid  (o_res_valid),
        .i_res_credit (i_res_credit),
        .o_fmt_err    (o_fmt_err)
    );

    always #50 clk = ~clk;

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input longint got, input longint exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Kind 0 is random operands, 1 mixes the two full-scale corners, 2 is all -32768.
    task automatic queue_vector(input logic [7:0] len, input int kind);
        dot_word_t   w;
        dot_result_t r;
        shortint     a;
        shortint     b;
        longint      acc;
        int          i;
        acc = 0;
        w = '0;
        w.is_header = 1'b1;
        w.payload.header.tag      = 8'($random(seed));
        w.payload.header.length   = len;
        w.payload.header.reserved = 16'($random(seed));
        tx_q.push_back(w);
        r.tag    = w.payload.header.tag;
        r.length = len;
        for (i = 0; i < int'(len); i++) begin
            if (kind == 2) begin
                a = 16'sh8000;
                b = 16'sh8000;
            end else if (kind == 1) begin
                a = ($random(seed) & 1) ? 16'sh8000 : 16'sh7fff;
                b = ($random(seed) & 1) ? 16'sh8000 : 16'sh7fff;
            end else begin
                a = shortint'($random(seed));
                b = shortint'($random(seed));
            end
            w = '0;
            w.payload.pair.a = a;
            w.payload.pair.b = b;
            tx_q.push_back(w);
            acc = acc + longint'(a) * longint'(b);
        end
        r.sum = acc[31:0];                     // The engine keeps only 32 bits.
        exp_q.push_back(r);
    endtask

    task automatic wait_idle(input string what);
        int cycles;
        cycles = 0;
        while (tx_q.size() != 0 || exp_q.size() != 0 || res_owed != 0) begin
            if (cycles == TIMEOUT_CYCLES) begin
                $display("Timed out after %0d cycles waiting for %s to finish.", cycles, what);
                stop_run();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // ##########################################################
    // Sender and receiver, both credit based
    // ##########################################################

    always @(posedge clk) begin
        if (tx_q.size() != 0 && in_credits != 0 && ($random(seed) & 3) != 0) begin
            next_word = tx_q.pop_front();
            i_in_valid <= 1'b1;
            i_in_word  <= next_word;
            in_credits = in_credits - 1;
        end else begin
            i_in_valid <= 1'b0;
        end
        if (res_owed != 0 && !hold_credits && ($random(seed) & 1) != 0) begin
            i_res_credit <= 1'b1;
            res_owed = res_owed - 1;
        end else begin
            i_res_credit <= 1'b0;
        end
    end

    // Outputs are read mid-cycle, away from the driving edge.
    always @(negedge clk) begin
        if (!i_rst) begin
            if (o_in_credit) begin
                in_credits  = in_credits + 1;
                in_returned = in_returned + 1;
            end
            if (o_res_valid) begin
                if (exp_q.size() == 0) begin
                    $display("A result with tag %0h arrived with no vector outstanding.",
                             o_res.tag);
                    stop_run();
                end
                expd = exp_q.pop_front();
                check_value("o_res.tag", o_res.tag, expd.tag);
                check_value("o_res.length", o_res.length, expd.length);
                check_value("o_res.sum", o_res.sum, expd.sum);
                res_owed  = res_owed + 1;
                res_count = res_count + 1;
            end
        end
    end

    // ##########################################################
    // Test sequence
    // ##########################################################

    initial begin
        seed         = 55489;
        clk          = 1'b0;
        i_rst        = 1'b1;
        i_in_valid   = 1'b0;
        i_in_word    = '0;
        i_res_credit = 1'b0;
        in_credits   = `DOT_IN_CREDITS;
        in_returned  = 0;
        res_owed     = 0;
        res_count    = 0;
        hold_credits = 1'b0;
        repeat (4) @(posedge clk);
        i_rst <= 1'b0;
        @(negedge clk);

        for (n = 0; n < 30; n++) begin
            if (n % 7 == 3) begin
                queue_vector(8'd0, 0);         // Empty vector.
            end else begin
                queue_vector(8'(1 + ({$random(seed)} % 12)), 0);
            end
        end
        wait_idle("random vectors");

        queue_vector(8'd3, 2);                 // Three times 2^30, wraps negative.
        queue_vector(8'd12, 2);                // Twelve times 2^30, wraps to zero.
        queue_vector(8'd1, 2);
        for (n = 0; n < 6; n++) begin
            queue_vector(8'(1 + ({$random(seed)} % 12)), 1);
        end
        wait_idle("full-scale vectors");

        // Receiver stops returning credits, so the engine must stall.
        hold_credits = 1'b1;
        res_mark = res_count;
        for (n = 0; n < 6; n++) begin
            queue_vector(8'd3, 0);
        end
        repeat (150) @(negedge clk);
        check_value("results while credits held", res_count - res_mark, `DOT_OUT_CREDITS);
        check_value("in_credits while stalled", in_credits, 0);
        check_value("words still queued", tx_q.size() != 0, 1);
        ret_mark = in_returned;
        repeat (100) @(negedge clk);
        check_value("o_in_credit pulses while stalled", in_returned - ret_mark, 0);
        hold_credits = 1'b0;
        wait_idle("stalled vectors");

        check_value("o_fmt_err", o_fmt_err, 0);
        stray = '0;
        stray.payload.pair.a = 16'($random(seed));
        stray.payload.pair.b = 16'($random(seed));
        tx_q.push_back(stray);                 // Pair where a header belongs.
        for (n = 0; n < 5; n++) begin
            queue_vector(8'(1 + ({$random(seed)} % 12)), 0);
        end
        wait_idle("vectors after a stray pair");
        check_value("o_fmt_err", o_fmt_err, 1);

        check_value("in_credits", in_credits, `DOT_IN_CREDITS);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: dot_engine_properties.sv
`timescale 1ns/1ns
`include "dot_config.svh"

module dot_engine_properties (
    input logic clk,
    input logic i_rst,
    input logic i_in_valid,
    input logic o_in_credit,
    input logic o_res_valid,
    input logic i_res_credit,
    input logic o_fmt_err
);

    int unsigned in_cred;                      // Credits the sender should hold.
    int unsigned out_cred;                     // Credits the engine should hold.
    int unsigned in_flight;                    // Words accepted and not yet credited.

    // ##########################################################
    // Shadow credit counters
    // ##########################################################

    always_ff @(posedge clk) begin
        if (i_rst) begin
            in_cred   <= `DOT_IN_CREDITS;
            out_cred  <= `DOT_OUT_CREDITS;
            in_flight <= 0;
        end else begin
            in_cred   <= in_cred + 32'(o_in_credit) - 32'(i_in_valid);
            out_cred  <= out_cred + 32'(i_res_credit) - 32'(o_res_valid);
            in_flight <= in_flight + 32'(i_in_valid) - 32'(o_in_credit);
        end
    end

    a_res_credit: assert property (@(posedge clk) disable iff (i_rst)
        o_res_valid |-> out_cred != 0)
        else $error("Result issued while the engine held no output credit.");

    a_in_credit: assert property (@(posedge clk) disable iff (i_rst)
        i_in_valid |-> in_cred != 0)
        else $error("Word sent while the sender held no input credit.");

    a_credit_return: assert property (@(posedge clk) disable iff (i_rst)
        o_in_credit |-> in_flight != 0)
        else $error("Input credit returned for a word never accepted.");

    a_fmt_sticky: assert property (@(posedge clk) disable iff (i_rst)
        !$fell(o_fmt_err))
        else $error("Format error flag cleared outside reset.");

endmodule

// File: dot_engine_top.sv
`timescale 1ns/1ns

module dot_engine_top
    import dot_stream_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_in_valid,
    input  dot_word_t   i_in_word,
    output logic        o_in_credit,
    output logic        o_res_valid,
    output dot_result_t o_res,
    input  logic        i_res_credit,
    output logic        o_fmt_err
);

    logic      q_valid;
    dot_word_t q_word;
    logic      q_pop;

    // Credit-based input queue.
    dot_ingress i_dot_ingress (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_valid  (i_in_valid),
        .i_word   (i_in_word),
        .i_pop    (q_pop),
        .o_valid  (q_valid),
        .o_word   (q_word),
        .o_credit (o_in_credit)
    );

    // Vector FSM with the MAC block inside.
    dot_sequencer i_dot_sequencer (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_q_valid    (q_valid),
        .i_q_word     (q_word),
        .o_q_pop      (q_pop),
        .i_res_credit (i_res_credit),
        .o_res_valid  (o_res_valid),
        .o_res        (o_res),
        .o_fmt_err    (o_fmt_err)
    );

endmodule

// File: dot_sequencer.sv
`timescale 1ns/1ns
`include "dot_config.svh"

module dot_sequencer
    import mac_types_pkg::*;
    import dot_stream_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_q_valid,
    input  dot_word_t   i_q_word,
    output logic        o_q_pop,
    input  logic        i_res_credit,
    output logic        o_res_valid,
    output dot_result_t o_res,
    output logic        o_fmt_err
);

    localparam int OCNT_W  = $clog2(`DOT_OUT_CREDITS + 1);
    localparam int DRAIN_W = $clog2(`DOT_DRAIN_CYCLES + 1);

    typedef enum logic [1:0] {ST_HEADER, ST_PAIRS, ST_DRAIN, ST_ISSUE} state_t;

    state_t             state;
    logic [7:0]         len_left;
    logic [DRAIN_W-1:0] drain_cnt;
    logic [OCNT_W-1:0]  out_cred;
    dot_result_t        res_q;
    logic               fmt_err_q;
    logic               hdr_in;
    logic               pair_in;
    logic               res_fire;
    logic               mac_clr;
    logic               mac_ce;
    mac_operand_t       mac_a;
    mac_operand_t       mac_b;
    mac_acc_t           mac_acc;

    assign hdr_in   = i_q_valid && i_q_word.is_header;
    assign pair_in  = i_q_valid && !i_q_word.is_header;
    assign o_q_pop  = i_q_valid && (state == ST_HEADER || state == ST_PAIRS);
    assign mac_clr  = (state == ST_HEADER) && hdr_in;  // Clear at the header pop.
    assign mac_ce   = (state == ST_PAIRS) && pair_in;
    assign mac_a    = i_q_word.payload.pair.a;
    assign mac_b    = i_q_word.payload.pair.b;
    assign res_fire = (state == ST_ISSUE) && (out_cred != '0);

    assign o_res_valid = res_fire;
    assign o_res       = res_q;
    assign o_fmt_err   = fmt_err_q;

    mac16_accum i_mac16_accum (
        .clk   (clk),
        .i_rst (i_rst),
        .i_clr (mac_clr),
        .i_ce  (mac_ce),
        .i_a   (mac_a),
        .i_b   (mac_b),
        .o_acc (mac_acc)
    );

    // ##########################################################
    // Vector FSM
    // ##########################################################

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state     <= ST_HEADER;
            len_left  <= '0;
            drain_cnt <= '0;
            fmt_err_q <= 1'b0;
        end else begin
            case (state)
                ST_HEADER: begin
                    if (hdr_in) begin
                        len_left <= i_q_word.payload.header.length;
                        if (i_q_word.payload.header.length == '0) begin
                            drain_cnt <= '0;            // Sum of a cleared MAC.
                            state     <= ST_DRAIN;
                        end else begin
                            state <= ST_PAIRS;
                        end
                    end else if (pair_in) begin
                        fmt_err_q <= 1'b1;              // Stray pair is dropped.
                    end
                end
                ST_PAIRS: begin
                    if (pair_in) begin
                        len_left <= len_left - 1'b1;
                        if (len_left == 8'd1) begin
                            drain_cnt <= DRAIN_W'(`DOT_DRAIN_CYCLES - 1);
                            state     <= ST_DRAIN;
                        end
                    end else if (hdr_in) begin
                        fmt_err_q <= 1'b1;
                    end
                end
                ST_DRAIN: begin
                    if (drain_cnt == '0) begin
                        state <= ST_ISSUE;
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                ST_ISSUE: begin
                    if (res_fire) begin
                        state <= ST_HEADER;
                    end
                end
                default: state <= ST_HEADER;
            endcase
        end
    end

    // Result record is filled in two steps: tag and length at the header,
    // sum once the last product has settled.
    always_ff @(posedge clk) begin
        if (mac_clr) begin
            res_q.tag    <= i_q_word.payload.header.tag;
            res_q.length <= i_q_word.payload.header.length;
        end
        if (state == ST_DRAIN && drain_cnt == '0) begin
            res_q.sum <= mac_acc;
        end
    end

    // Spent and returned credits can meet in one cycle and cancel.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            out_cred <= OCNT_W'(`DOT_OUT_CREDITS);
        end else if (i_res_credit && !res_fire) begin
            out_cred <= out_cred + 1'b1;
        end else if (res_fire && !i_res_credit) begin
            out_cred <= out_cred - 1'b1;
        end
    end

endmodule

// File: dot_ingress.sv
`timescale 1ns/1ns
`include "dot_config.svh"

module dot_ingress
    import dot_stream_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_valid,
    input  dot_word_t i_word,
    input  logic      i_pop,
    output logic      o_valid,
    output dot_word_t o_word,
    output logic      o_credit
);

    localparam int DEPTH = `DOT_IN_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    dot_word_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;
    logic             credit_q;

    assign o_valid  = (count != '0);
    assign o_word   = mem[rd_ptr];
    assign pop      = i_pop && o_valid;        // Only a real word is consumed.
    assign o_credit = credit_q;

    // ##########################################################
    // Storage
    // ##########################################################

    // The sender spends a credit per word, so a write never finds the
    // queue full.
    always_ff @(posedge clk) begin
        if (i_valid) begin
            mem[wr_ptr] <= i_word;
        end
    end

    // ##########################################################
    // Pointers, occupancy and credit return
    // ##########################################################

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_q <= 1'b0;
        end else begin
            credit_q <= pop;                   // One credit back per pop.

            if (i_valid) begin
                wr_ptr <= wr_ptr + 1'b1;       // Depth is a power of two.
            end

            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (i_valid && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !i_valid) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: mac16_accum.sv
`timescale 1ns/1ns

module mac16_accum
    import mac_types_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst,
    input  logic         i_clr,
    input  logic         i_ce,
    input  mac_operand_t i_a,
    input  mac_operand_t i_b,
    output mac_acc_t     o_acc
);

    mac_operand_t a_q;
    mac_operand_t b_q;
    logic         prod_vld;
    mac_product_t product;
    mac_acc_t     acc_q;

    // ##########################################################
    // Input register stage
    // ##########################################################

    always_ff @(posedge clk) begin
        if (i_rst || i_clr) begin
            a_q      <= '0;
            b_q      <= '0;
            prod_vld <= 1'b0;
        end else begin
            prod_vld <= i_ce;                  // Marks a fresh pair in A and B.
            if (i_ce) begin
                a_q <= i_a;
                b_q <= i_b;
            end
        end
    end

    assign product = a_q * b_q;                // Both operands signed.

    // ##########################################################
    // Accumulator stage
    // ##########################################################

    // A pair captured at one edge lands in the accumulator at the next,
    // so back-to-back pairs overlap across the two stages.
    always_ff @(posedge clk) begin
        if (i_rst || i_clr) begin
            acc_q <= '0;
        end else if (prod_vld) begin
            acc_q <= acc_q + product;          // Wraps modulo 2^32.
        end
    end

    assign o_acc = acc_q;

endmodule

// File: dot_stream_pkg.sv
package dot_stream_pkg;

    import mac_types_pkg::*;

    // ##########################################################
    // Input word, decoded as a header or as an operand pair
    // ##########################################################

    typedef struct packed {
        logic [7:0]  tag;
        logic [7:0]  length;   // Number of pairs that follow.
        logic [15:0] reserved;
    } dot_header_t;

    typedef struct packed {
        mac_operand_t a;
        mac_operand_t b;
    } dot_pair_t;

    typedef union packed {
        dot_header_t header;
        dot_pair_t   pair;
    } dot_payload_u;

    typedef struct packed {
        logic         is_header; // Selects which view of the payload applies.
        dot_payload_u payload;
    } dot_word_t;

    // One record per vector on the output channel.
    typedef struct packed {
        logic [7:0] tag;
        logic [7:0] length;
        mac_acc_t   sum;
    } dot_result_t;

endpackage

// File: mac_types_pkg.sv
package mac_types_pkg;

    // ##########################################################
    // Widths of the 16x16 multiply-accumulate datapath
    // ##########################################################

    localparam int MAC_OPERAND_W = 16;
    localparam int MAC_ACC_W     = 32;

    // One signed operand as it enters the A or B register.
    typedef logic signed [MAC_OPERAND_W-1:0] mac_operand_t;

    // Full-width signed product of two operands.
    typedef logic signed [2*MAC_OPERAND_W-1:0] mac_product_t;

    // Accumulator and final sum. Wraps modulo 2^32 like the hard tile.
    typedef logic signed [MAC_ACC_W-1:0] mac_acc_t;

endpackage

// File: dot_config.svh
`ifndef DOT_CONFIG_SVH
`define DOT_CONFIG_SVH

// ##########################################################
// Input channel
// ##########################################################

// Queue depth, also the credits the sender holds after reset.
`define DOT_IN_CREDITS 4

// ##########################################################
// Output channel and MAC pipeline
// ##########################################################

// Results the receiver can take before it returns credits.
`define DOT_OUT_CREDITS 2

// Edges from the last pair pop until the accumulator is final.
`define DOT_DRAIN_CYCLES 2

`endif
